// File: Bender.yml
package:
  name: vtb

sources:
  - common/vtb_pkg.sv
  - ctl/vtb_ctl.sv
  - logic/vtb_tg.sv
  - logic/vtb_tpg.sv
  - fifo/vtb_fifo.sv
  - logic/vtb_top.sv
  - target: test
    files:
      - test/vtb_tb_clk.sv
      - test/vtb_tb.sv

// File: build.f
common/vtb_pkg.sv
ctl/vtb_ctl.sv
logic/vtb_tg.sv
logic/vtb_tpg.sv
fifo/vtb_fifo.sv
logic/vtb_top.sv
test/vtb_tb_clk.sv
test/vtb_tb.sv

// File: common/vtb_pkg.sv
// ######################################
// Shared widths, types and register map
// Two pixels per clock, 8 bits per component
// Counts are 12 bits, totals must stay below 4096
// ######################################

package vtb_pkg;

	// Pixel format
	localparam int PPC = 2;		// Pixels per clock
	localparam int BPC = 8;		// Bits per component

	typedef logic [PPC*BPC-1:0] comp_t;	// Lane 0 in the low bits

	typedef struct packed
	{
		comp_t r;
		comp_t g;
		comp_t b;
	} pix_t;

	// Horizontal counts in clocks, vertical in lines
	typedef logic [11:0] cnt_t;

	localparam cnt_t HS_WIDTH = 12'd4;	// Clocks
	localparam cnt_t VS_WIDTH = 12'd2;	// Lines

	// Stream FIFO
	localparam int FIFO_DEPTH = 64;
	typedef logic [6:0] lvl_t;	// Holds 0 up to FIFO_DEPTH
	typedef logic [$clog2(FIFO_DEPTH)-1:0] fadr_t;

	// Video parameter set
	typedef struct packed
	{
		cnt_t h_total;
		cnt_t h_active;
		cnt_t v_total;
		cnt_t v_active;
	} vps_t;

	// Native video
	typedef struct packed
	{
		logic vs;
		logic hs;
		logic de;
		pix_t pix;
	} vid_t;

	// Stream beat
	typedef struct packed
	{
		logic sof;	// First beat of a frame
		logic eol;	// Last beat of a line
		pix_t dat;
	} axis_t;

	// Pixel pair column and line inside the active area
	typedef struct packed
	{
		cnt_t x;
		cnt_t y;
	} pos_t;

	// Local bus
	typedef logic [3:0] lb_adr_t;
	typedef logic [31:0] lb_dat_t;

	typedef struct packed
	{
		logic    wr;	// 1 write, 0 read
		lb_adr_t adr;
		lb_dat_t wdat;
	} lb_req_t;

	// Control register, vid_en ends up in bit 0
	typedef struct packed
	{
		logic fifo_run;	// Bit 4
		logic tpg_run;	// Bit 3, selects the pattern on vid
		logic tg_mode;	// Bit 2, 0 free running, 1 locked to FIFO
		logic tg_run;	// Bit 1
		logic vid_en;	// Bit 0, holds the video path in reset when low
	} ctl_t;

	// Status towards the register block
	typedef struct packed
	{
		logic lock;
		logic underrun;		// Sticky
		lvl_t max_lvl;
		cnt_t line_words;
		cnt_t frame_lines;
	} sta_t;

	// Register addresses
	localparam lb_adr_t ADR_CTL = 4'd0;
	localparam lb_adr_t ADR_HOR = 4'd1;
	localparam lb_adr_t ADR_VER = 4'd2;
	localparam lb_adr_t ADR_STA = 4'd3;
	localparam lb_adr_t ADR_MON = 4'd4;

	// Timing generator states
	typedef enum logic [1:0]
	{
		TG_IDLE,
		TG_WAIT,
		TG_RUN
	} tg_state_t;

endpackage

// File: ctl/vtb_ctl.sv
// ######################################
// Register block on the local bus
// One outstanding read, data 1 cycle after accept
// lb_rdy drops only in the response cycle
// Unmapped addresses read 0, writes to them are ignored
// ######################################

`timescale 1ns/1ns

module vtb_ctl
(
	input  logic				vid_clk,	// Bus runs on the video clock
	input  logic				rst_n,

	// Local bus
	input  vtb_pkg::lb_req_t	lb_req,
	input  logic				lb_vld,
	output logic				lb_rdy,
	output vtb_pkg::lb_dat_t	lb_rdata,
	output logic				lb_rd_vld,

	// Status in
	input  vtb_pkg::sta_t		sta,

	// Control out
	output vtb_pkg::ctl_t		ctl,
	output vtb_pkg::vps_t		vps,
	output logic				sta_clr		// Clears underrun and max_lvl
);

	logic				acc;		// Request accepted
	logic				wr_acc;
	logic				rd_acc;
	vtb_pkg::lb_dat_t	rd_dat;		// Read mux

	assign lb_rdy = !lb_rd_vld;		// Busy while returning data
	assign acc = lb_vld && lb_rdy;
	assign wr_acc = acc && lb_req.wr;
	assign rd_acc = acc && !lb_req.wr;

	// Status clear, FIFO acts on it at the next edge
	assign sta_clr = wr_acc && (lb_req.adr == vtb_pkg::ADR_STA);

	// Write decode
	always_ff @(posedge vid_clk)
	begin
		if (!rst_n)
		begin
			ctl <= '0;
			vps <= '0;
		end
		else if (wr_acc)
		begin
			case (lb_req.adr)
				vtb_pkg::ADR_CTL:
					ctl <= vtb_pkg::ctl_t'(lb_req.wdat[$bits(vtb_pkg::ctl_t)-1:0]);
				vtb_pkg::ADR_HOR:
				begin
					vps.h_active <= lb_req.wdat[11:0];
					vps.h_total <= lb_req.wdat[27:16];
				end
				vtb_pkg::ADR_VER:
				begin
					vps.v_active <= lb_req.wdat[11:0];
					vps.v_total <= lb_req.wdat[27:16];
				end
				default: ;	// Status and monitor are read only
			endcase
		end
	end

	// Read mux
	always_comb
	begin
		rd_dat = '0;
		case (lb_req.adr)
			vtb_pkg::ADR_CTL:
				rd_dat[$bits(vtb_pkg::ctl_t)-1:0] = ctl;
			vtb_pkg::ADR_HOR:
				rd_dat = {4'h0, vps.h_total, 4'h0, vps.h_active};
			vtb_pkg::ADR_VER:
				rd_dat = {4'h0, vps.v_total, 4'h0, vps.v_active};
			vtb_pkg::ADR_STA:
				rd_dat = {17'h0, sta.max_lvl, 6'h0, sta.underrun, sta.lock};
			vtb_pkg::ADR_MON:
				rd_dat = {4'h0, sta.frame_lines, 4'h0, sta.line_words};
			default:
				rd_dat = '0;	// Unmapped
		endcase
	end

	// Read response valid
	always_ff @(posedge vid_clk)
	begin
		if (!rst_n)
			lb_rd_vld <= 1'b0;
		else
			lb_rd_vld <= rd_acc;	// One cycle pulse per read
	end

	// Read data, only loaded on a read
	always_ff @(posedge vid_clk)
	begin
		if (rd_acc)
			lb_rdata <= rd_dat;
	end

endmodule

// File: fifo/vtb_fifo.sv
// ######################################
// Stream FIFO locked to the timing generator
// Locks on a head sof during vertical blanking
// Empty during de drops lock and sets underrun
// Clearing fifo_run flushes the words
// ######################################

`timescale 1ns/1ns

module vtb_fifo
(
	input  logic				vid_clk,
	input  logic				rst_n,
	input  vtb_pkg::ctl_t		ctl,
	input  logic				sta_clr,
	input  vtb_pkg::axis_t		axis,
	input  logic				axis_vld,
	output logic				axis_rdy,
	input  vtb_pkg::vid_t		tim,
	output logic				lock,
	output vtb_pkg::sta_t		sta,
	output vtb_pkg::vid_t		vid
);

	vtb_pkg::axis_t	mem [vtb_pkg::FIFO_DEPTH];
	vtb_pkg::fadr_t	wr_ptr;
	vtb_pkg::fadr_t	rd_ptr;
	vtb_pkg::lvl_t	lvl;
	vtb_pkg::axis_t	head;		// Word at the read pointer
	logic			full;
	logic			empty;
	logic			push;
	logic			pop;
	logic			under;		// Empty while draining
	logic			blank;		// Between vs and first de
	logic			underrun;
	vtb_pkg::lvl_t	max_lvl;
	vtb_pkg::cnt_t	wrd_cnt;	// Beats in current line
	vtb_pkg::cnt_t	lin_cnt;	// Lines since sof
	vtb_pkg::cnt_t	line_words;
	vtb_pkg::cnt_t	frame_lines;

	assign full = (lvl == vtb_pkg::lvl_t'(vtb_pkg::FIFO_DEPTH));
	assign empty = (lvl == '0);
	assign axis_rdy = ctl.vid_en && ctl.fifo_run && !full;
	assign push = axis_vld && axis_rdy;
	assign pop = lock && tim.de && !empty;
	assign under = lock && tim.de && empty;
	assign head = mem[rd_ptr];

	// Storage
	always_ff @(posedge vid_clk)
	begin
		if (push)
			mem[wr_ptr] <= axis;
	end

	// Pointers and level
	always_ff @(posedge vid_clk)
	begin
		if (!rst_n || !ctl.vid_en || !ctl.fifo_run)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			lvl <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			lvl <= lvl + vtb_pkg::lvl_t'(push) - vtb_pkg::lvl_t'(pop);
		end
	end

	// Lock to frame start
	always_ff @(posedge vid_clk)
	begin
		if (!rst_n || !ctl.vid_en)
		begin
			lock <= 1'b0;
			blank <= 1'b1;		// Idle TG counts as blanking
		end
		else
		begin
			if (tim.vs)
				blank <= 1'b1;
			else if (tim.de)
				blank <= 1'b0;

			if (!ctl.fifo_run || under)
				lock <= 1'b0;
			else if (!empty && head.sof && blank && !tim.de)
				lock <= 1'b1;	// First de after this pops sof
		end
	end

	// Sticky status
	always_ff @(posedge vid_clk)
	begin
		if (!rst_n || !ctl.vid_en || sta_clr)
		begin
			underrun <= 1'b0;
			max_lvl <= '0;
		end
		else
		begin
			if (under)
				underrun <= 1'b1;
			if (lvl > max_lvl)
				max_lvl <= lvl;		// High water mark
		end
	end

	// Input monitor
	always_ff @(posedge vid_clk)
	begin
		if (!rst_n || !ctl.vid_en)
		begin
			wrd_cnt <= '0;
			lin_cnt <= '0;
			line_words <= '0;
			frame_lines <= '0;
		end
		else if (push)
		begin
			if (axis.eol)
			begin
				line_words <= wrd_cnt + 12'd1;	// Includes the eol beat
				wrd_cnt <= '0;
				lin_cnt <= (axis.sof ? 12'd0 : lin_cnt) + 12'd1;
				frame_lines <= (axis.sof ? 12'd0 : lin_cnt) + 12'd1;	// Running count
			end
			else
			begin
				wrd_cnt <= wrd_cnt + 12'd1;
				if (axis.sof)
					lin_cnt <= '0;		// Restart line count
			end
		end
	end

	// Video out, 1 cycle after tim
	always_ff @(posedge vid_clk)
	begin
		if (!rst_n || !ctl.vid_en)
			vid <= '0;
		else
		begin
			vid.vs <= tim.vs;
			vid.hs <= tim.hs;
			vid.de <= tim.de;
			vid.pix <= pop ? head.dat : '0;		// Zero when not locked or empty
		end
	end

	always_comb
	begin
		sta.lock = lock;
		sta.underrun = underrun;
		sta.max_lvl = max_lvl;
		sta.line_words = line_words;
		sta.frame_lines = frame_lines;
	end

endmodule

// File: logic/vtb_tg.sv
// ######################################
// Video timing generator
// Free mode starts 1 cycle after tg_run
// Sync mode waits for FIFO lock at frame start
// Needs h_total > h_active + HS_WIDTH, totals nonzero
// ######################################

`timescale 1ns/1ns

module vtb_tg
(
	input  logic				vid_clk,
	input  logic				rst_n,
	input  vtb_pkg::ctl_t		ctl,
	input  vtb_pkg::vps_t		vps,
	input  logic				lock,	// From FIFO
	output vtb_pkg::vid_t		tim,	// Sync and de, pixels zero
	output vtb_pkg::pos_t		pos
);

	vtb_pkg::tg_state_t	state;
	vtb_pkg::vps_t		vps_q;		// Parameters of the current frame
	vtb_pkg::cnt_t		h_cnt;		// Clock in line
	vtb_pkg::cnt_t		v_cnt;		// Line in frame
	logic				h_end;
	logic				v_end;
	logic				run;

	assign h_end = (h_cnt == vps_q.h_total - 12'd1);
	assign v_end = (v_cnt == vps_q.v_total - 12'd1);
	assign run = (state == vtb_pkg::TG_RUN);

	always_ff @(posedge vid_clk)
	begin
		if (!rst_n || !ctl.vid_en)
		begin
			state <= vtb_pkg::TG_IDLE;
			vps_q <= '0;
			h_cnt <= '0;
			v_cnt <= '0;
		end
		else
		begin
			case (state)
				vtb_pkg::TG_IDLE:
				begin
					h_cnt <= '0;
					v_cnt <= '0;
					if (ctl.tg_run)
					begin
						vps_q <= vps;
						state <= ctl.tg_mode ? vtb_pkg::TG_WAIT : vtb_pkg::TG_RUN;
					end
				end

				vtb_pkg::TG_WAIT:
				begin
					if (!ctl.tg_run)
						state <= vtb_pkg::TG_IDLE;
					else if (lock)
					begin
						vps_q <= vps;		// Frame start
						state <= vtb_pkg::TG_RUN;
					end
				end

				vtb_pkg::TG_RUN:
				begin
					if (!ctl.tg_run)
						state <= vtb_pkg::TG_IDLE;	// Stop at once
					else if (h_end)
					begin
						h_cnt <= '0;
						if (v_end)
						begin
							v_cnt <= '0;
							vps_q <= vps;	// New frame, fresh parameters
							if (ctl.tg_mode && !lock)
								state <= vtb_pkg::TG_WAIT;	// Lost lock, resync
						end
						else
							v_cnt <= v_cnt + 12'd1;
					end
					else
						h_cnt <= h_cnt + 12'd1;
				end

				default:
					state <= vtb_pkg::TG_IDLE;
			endcase
		end
	end

	// Frame decode
	always_comb
	begin
		tim = '0;
		tim.de = run && (h_cnt < vps_q.h_active) && (v_cnt < vps_q.v_active);
		tim.hs = run && (h_cnt >= vps_q.h_active)
			&& (h_cnt < vps_q.h_active + vtb_pkg::HS_WIDTH);
		tim.vs = run && (v_cnt >= vps_q.v_active)
			&& (v_cnt < vps_q.v_active + vtb_pkg::VS_WIDTH);
		pos.x = h_cnt;		// Pixel pair column
		pos.y = v_cnt;
	end

endmodule

// File: logic/vtb_top.sv
// ######################################
// Video toolbox top, single clock
// Pattern or FIFO video, chosen by tpg_run
// Video 1 cycle behind the timing generator
// ######################################

`timescale 1ns/1ns

module vtb_top
(
	input  logic				vid_clk,
	input  logic				rst_n,

	// Local bus
	input  vtb_pkg::lb_req_t	lb_req,
	input  logic				lb_vld,
	output logic				lb_rdy,
	output vtb_pkg::lb_dat_t	lb_rdata,
	output logic				lb_rd_vld,

	// Pixel stream
	input  vtb_pkg::axis_t		axis,
	input  logic				axis_vld,
	output logic				axis_rdy,

	// Native video
	output vtb_pkg::vid_t		vid
);

	vtb_pkg::ctl_t	ctl;
	vtb_pkg::vps_t	vps;
	vtb_pkg::sta_t	sta;
	logic			sta_clr;
	logic			lock;		// FIFO to TG
	vtb_pkg::vid_t	tim;
	vtb_pkg::pos_t	pos;
	vtb_pkg::vid_t	vid_tpg;
	vtb_pkg::vid_t	vid_fifo;

	vtb_ctl ctl_i
	(
		.vid_clk	(vid_clk),
		.rst_n		(rst_n),
		.lb_req		(lb_req),
		.lb_vld		(lb_vld),
		.lb_rdy		(lb_rdy),
		.lb_rdata	(lb_rdata),
		.lb_rd_vld	(lb_rd_vld),
		.sta		(sta),
		.ctl		(ctl),
		.vps		(vps),
		.sta_clr	(sta_clr)
	);

	vtb_tg tg_i
	(
		.vid_clk	(vid_clk),
		.rst_n		(rst_n),
		.ctl		(ctl),
		.vps		(vps),
		.lock		(lock),
		.tim		(tim),
		.pos		(pos)
	);

	vtb_tpg tpg_i
	(
		.vid_clk	(vid_clk),
		.rst_n		(rst_n),
		.ctl		(ctl),
		.tim		(tim),
		.pos		(pos),
		.vid		(vid_tpg)
	);

	vtb_fifo fifo_i
	(
		.vid_clk	(vid_clk),
		.rst_n		(rst_n),
		.ctl		(ctl),
		.sta_clr	(sta_clr),
		.axis		(axis),
		.axis_vld	(axis_vld),
		.axis_rdy	(axis_rdy),
		.tim		(tim),
		.lock		(lock),
		.sta		(sta),
		.vid		(vid_fifo)
	);

	assign vid = ctl.tpg_run ? vid_tpg : vid_fifo;	// Both already registered

endmodule

// File: logic/vtb_tpg.sv
// ######################################
// Test pattern generator
// Red is pixel index, green is line, blue their xor
// Output registered 1 cycle after tim
// ######################################

`timescale 1ns/1ns

module vtb_tpg
(
	input  logic				vid_clk,
	input  logic				rst_n,
	input  vtb_pkg::ctl_t		ctl,
	input  vtb_pkg::vid_t		tim,
	input  vtb_pkg::pos_t		pos,
	output vtb_pkg::vid_t		vid
);

	vtb_pkg::pix_t	pix_nxt;
	vtb_pkg::cnt_t	p_idx;		// Pixel index in line
	vtb_pkg::cnt_t	pq;			// Pixel xor line

	// Pattern for all lanes of this clock
	always_comb
	begin
		pix_nxt = '0;
		p_idx = '0;
		pq = '0;
		for (int k = 0; k < vtb_pkg::PPC; k++)
		begin
			p_idx = vtb_pkg::cnt_t'(pos.x * vtb_pkg::PPC + k);
			pq = p_idx ^ pos.y;
			pix_nxt.r[k*vtb_pkg::BPC +: vtb_pkg::BPC] = p_idx[vtb_pkg::BPC-1:0];
			pix_nxt.g[k*vtb_pkg::BPC +: vtb_pkg::BPC] = pos.y[vtb_pkg::BPC-1:0];
			pix_nxt.b[k*vtb_pkg::BPC +: vtb_pkg::BPC] = pq[vtb_pkg::BPC-1:0];
		end
	end

	// Output stage
	always_ff @(posedge vid_clk)
	begin
		if (!rst_n || !ctl.vid_en || !ctl.tpg_run)	// Idle when not selected
			vid <= '0;
		else
		begin
			vid.vs <= tim.vs;
			vid.hs <= tim.hs;
			vid.de <= tim.de;
			vid.pix <= tim.de ? pix_nxt : '0;	// Black in blanking
		end
	end

endmodule

// File: test/vtb_tb.sv
// ########################################
// Testbench for the video toolbox top
// Frame 16x8 clocks, active 6 clocks by 4 lines
// Outputs sampled on the falling edge
// Stops at the first mismatch
// ########################################

`timescale 1ns/1ns

module vtb_tb;

	localparam int H_TOTAL = 16;
	localparam int H_ACT = 6;
	localparam int V_TOTAL = 8;
	localparam int V_ACT = 4;
	localparam int BUS_TMO = 16;		// Cycles
	localparam int VID_TMO = 1000;
	localparam int WDOG_CYC = 20000;

	typedef enum logic [2:0]
	{
		WR_REG,
		RD_REG,
		TPG_FRAME,
		STRM_FRAME,
		FIFO_FILL
	} step_kind_t;

	// One row of the stimulus table
	typedef struct packed
	{
		step_kind_t			kind;
		vtb_pkg::lb_adr_t	adr;
		vtb_pkg::lb_dat_t	dat;	// Write data, expected read data or line count
		vtb_pkg::lb_dat_t	msk;	// Read compare mask
	} step_t;

	logic				vid_clk;
	logic				rst_n;
	vtb_pkg::lb_req_t	lb_req;
	logic				lb_vld;
	logic				lb_rdy;
	vtb_pkg::lb_dat_t	lb_rdata;
	logic				lb_rd_vld;
	vtb_pkg::axis_t		axis;
	logic				axis_vld;
	logic				axis_rdy;
	vtb_pkg::vid_t		vid;

	step_t			steps [$];
	vtb_pkg::pix_t	exp_q [$];		// Stream words still expected on vid
	logic [31:0]	rng = 32'hdf6a_a291;

	vtb_tb_clk clk_i
	(
		.vid_clk	(vid_clk),
		.rst_n		(rst_n)
	);

	vtb_top vtb_top_i
	(
		.vid_clk	(vid_clk),
		.rst_n		(rst_n),
		.lb_req		(lb_req),
		.lb_vld		(lb_vld),
		.lb_rdy		(lb_rdy),
		.lb_rdata	(lb_rdata),
		.lb_rd_vld	(lb_rd_vld),
		.axis		(axis),
		.axis_vld	(axis_vld),
		.axis_rdy	(axis_rdy),
		.vid		(vid)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1, "Run stopped");
	endtask

	task automatic check_dat(input string name, input vtb_pkg::lb_dat_t got,
		input vtb_pkg::lb_dat_t exp);
		if (got !== exp)
			abort_run($sformatf("Fail %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_vid(input string name, input vtb_pkg::vid_t got,
		input vtb_pkg::vid_t exp);
		if (got !== exp)
			abort_run($sformatf("Fail %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_lvl(input string name, input vtb_pkg::lvl_t got,
		input vtb_pkg::lvl_t exp);
		if (got !== exp)
			abort_run($sformatf("Fail %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("Fail %s: got %h, expected %h", name, got, exp));
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// 48 random bits from two draws
	task automatic random_pix(output vtb_pkg::pix_t px);
		logic [31:0] hi;
		rng = xorshift(rng);
		hi = rng;
		rng = xorshift(rng);
		px = {hi, rng[15:0]};
	endtask

	// Expected pattern, lane k holds pixel 2h+k
	function automatic vtb_pkg::pix_t tpg_pixel(input int h, input int v);
		vtb_pkg::pix_t px;
		int p;
		int pv;
		px = '0;
		for (int k = 0; k < vtb_pkg::PPC; k++)
		begin
			p = 2 * h + k;
			pv = p ^ v;
			px.r[k*vtb_pkg::BPC +: vtb_pkg::BPC] = p[7:0];
			px.g[k*vtb_pkg::BPC +: vtb_pkg::BPC] = v[7:0];
			px.b[k*vtb_pkg::BPC +: vtb_pkg::BPC] = pv[7:0];
		end
		return px;
	endfunction

	task automatic wait_reset();
		int n;
		n = 0;
		@(negedge vid_clk);
		while (!rst_n)
		begin
			n++;
			if (n > BUS_TMO)
				abort_run("Reset was never released");
			@(negedge vid_clk);
		end
	endtask

	// Hold the request until lb_rdy, accept on the next edge
	task automatic wait_bus_rdy(input string what);
		int n;
		n = 0;
		@(negedge vid_clk);
		while (!lb_rdy)
		begin
			n++;
			if (n > BUS_TMO)
				abort_run($sformatf("Local bus never accepted the %s", what));
			@(negedge vid_clk);
		end
	endtask

	task automatic bus_write(input vtb_pkg::lb_adr_t adr, input vtb_pkg::lb_dat_t dat);
		vtb_pkg::lb_req_t r;
		r.wr = 1'b1;
		r.adr = adr;
		r.wdat = dat;
		@(posedge vid_clk);
		lb_req <= r;
		lb_vld <= 1'b1;
		wait_bus_rdy("write");
		@(posedge vid_clk);		// Accept edge
		lb_vld <= 1'b0;
	endtask

	task automatic bus_read(input vtb_pkg::lb_adr_t adr, output vtb_pkg::lb_dat_t dat);
		vtb_pkg::lb_req_t r;
		r.wr = 1'b0;
		r.adr = adr;
		r.wdat = '0;
		@(posedge vid_clk);
		lb_req <= r;
		lb_vld <= 1'b1;
		wait_bus_rdy("read");
		@(posedge vid_clk);
		lb_vld <= 1'b0;
		@(negedge vid_clk);		// One cycle after accept
		check_bit("lb_rd_vld", lb_rd_vld, 1'b1);
		check_bit("lb_rdy", lb_rdy, 1'b0);	// Busy in the response cycle
		dat = lb_rdata;
	endtask

	// Drive one beat, return once it will be taken on the next edge
	task automatic send_beat(input vtb_pkg::axis_t b);
		int n;
		n = 0;
		@(posedge vid_clk);
		axis <= b;
		axis_vld <= 1'b1;
		@(negedge vid_clk);
		while (!axis_rdy)
		begin
			n++;
			if (n > VID_TMO)
				abort_run("Stream beat was never accepted");
			@(negedge vid_clk);
		end
	endtask

	task automatic send_frame(input int lines);
		vtb_pkg::axis_t b;
		vtb_pkg::pix_t px;
		for (int l = 0; l < lines; l++)
		begin
			for (int w = 0; w < H_ACT; w++)
			begin
				random_pix(px);
				b.sof = (l == 0) && (w == 0);
				b.eol = (w == H_ACT - 1);
				b.dat = px;
				exp_q.push_back(px);
				send_beat(b);
			end
		end
		@(posedge vid_clk);
		axis_vld <= 1'b0;
	endtask

	// Offer beats until axis_rdy drops
	task automatic fill_fifo();
		vtb_pkg::axis_t b;
		vtb_pkg::pix_t px;
		int acc;
		logic rdy;
		acc = 0;
		rdy = 1'b1;
		while (rdy)
		begin
			random_pix(px);
			b.sof = 1'b0;		// No sof, FIFO must not lock
			b.eol = 1'b0;
			b.dat = px;
			@(posedge vid_clk);
			axis <= b;
			axis_vld <= 1'b1;
			@(negedge vid_clk);
			rdy = axis_rdy;
			if (rdy)
				acc++;
			if (acc > 2 * vtb_pkg::FIFO_DEPTH)
				abort_run("axis_rdy stayed high past the FIFO size");
		end
		@(posedge vid_clk);
		axis_vld <= 1'b0;
		check_lvl("accepted beats", vtb_pkg::lvl_t'(acc),
			vtb_pkg::lvl_t'(vtb_pkg::FIFO_DEPTH));
	endtask

	task automatic wait_vid(input logic use_vs, input logic val, input string what);
		int n;
		n = 0;
		@(negedge vid_clk);
		while ((use_vs ? vid.vs : vid.de) !== val)
		begin
			n++;
			if (n > VID_TMO)
				abort_run($sformatf("Timed out waiting for %s on vid", what));
			@(negedge vid_clk);
		end
	endtask

	// Compare vid per clock from the first de of a frame
	task automatic check_frame(input logic from_tpg, input int ncyc);
		vtb_pkg::vid_t exp;
		int h;
		int v;
		if (from_tpg)
		begin
			wait_vid(1'b1, 1'b1, "vs high");	// Skip to a clean frame
			wait_vid(1'b1, 1'b0, "vs low");
		end
		wait_vid(1'b0, 1'b1, "first de");
		for (int c = 0; c < ncyc; c++)
		begin
			h = c % H_TOTAL;
			v = c / H_TOTAL;
			exp = '0;
			exp.de = (h < H_ACT) && (v < V_ACT);
			exp.hs = (h >= H_ACT) && (h < H_ACT + int'(vtb_pkg::HS_WIDTH));
			exp.vs = (v >= V_ACT) && (v < V_ACT + int'(vtb_pkg::VS_WIDTH));
			if (exp.de && from_tpg)
				exp.pix = tpg_pixel(h, v);
			else if (exp.de && exp_q.size() > 0)
				exp.pix = exp_q.pop_front();	// Zero once the stream ran dry
			check_vid($sformatf("vid line %0d clock %0d", v, h), vid, exp);
			@(negedge vid_clk);
		end
	endtask

	task automatic add_step(input step_kind_t k, input vtb_pkg::lb_adr_t a,
		input vtb_pkg::lb_dat_t d, input vtb_pkg::lb_dat_t m);
		step_t s;
		s.kind = k;
		s.adr = a;
		s.dat = d;
		s.msk = m;
		steps.push_back(s);
	endtask

	task automatic build_table();
		// Reset values
		add_step(RD_REG, vtb_pkg::ADR_CTL, 32'h0000_0000, 32'hffff_ffff);
		add_step(RD_REG, vtb_pkg::ADR_HOR, 32'h0000_0000, 32'hffff_ffff);
		add_step(RD_REG, vtb_pkg::ADR_VER, 32'h0000_0000, 32'hffff_ffff);
		// Register access, video held off
		add_step(WR_REG, vtb_pkg::ADR_HOR, 32'h0010_0006, 32'h0);	// Total 16, active 6
		add_step(WR_REG, vtb_pkg::ADR_VER, 32'h0008_0004, 32'h0);	// Total 8, active 4
		add_step(WR_REG, vtb_pkg::ADR_CTL, 32'h0000_0008, 32'h0);
		add_step(RD_REG, vtb_pkg::ADR_HOR, 32'h0010_0006, 32'hffff_ffff);
		add_step(RD_REG, vtb_pkg::ADR_VER, 32'h0008_0004, 32'hffff_ffff);
		add_step(RD_REG, vtb_pkg::ADR_CTL, 32'h0000_0008, 32'hffff_ffff);
		add_step(WR_REG, 4'h7, 32'hdead_beef, 32'h0);
		add_step(RD_REG, 4'h7, 32'h0000_0000, 32'hffff_ffff);	// Unmapped
		add_step(RD_REG, 4'hf, 32'h0000_0000, 32'hffff_ffff);
		// Pattern in free mode
		add_step(WR_REG, vtb_pkg::ADR_CTL, 32'h0000_000b, 32'h0);
		add_step(TPG_FRAME, 4'h0, 32'h0, 32'h0);
		add_step(WR_REG, vtb_pkg::ADR_CTL, 32'h0000_0000, 32'h0);
		// Stream in sync mode, status read before the next frame
		add_step(WR_REG, vtb_pkg::ADR_CTL, 32'h0000_0017, 32'h0);
		add_step(STRM_FRAME, 4'h0, V_ACT, 32'h0);
		add_step(RD_REG, vtb_pkg::ADR_MON, 32'h0004_0006, 32'hffff_ffff);
		add_step(RD_REG, vtb_pkg::ADR_STA, 32'h0000_0001, 32'h0000_0003);	// Locked, no underrun
		add_step(WR_REG, vtb_pkg::ADR_CTL, 32'h0000_0000, 32'h0);
		// Back-pressure with the TG stopped
		add_step(WR_REG, vtb_pkg::ADR_CTL, 32'h0000_0011, 32'h0);
		add_step(FIFO_FILL, 4'h0, 32'h0, 32'h0);
		add_step(RD_REG, vtb_pkg::ADR_STA, vtb_pkg::FIFO_DEPTH << 8, 32'h0000_7f00);
		add_step(WR_REG, vtb_pkg::ADR_CTL, 32'h0000_0000, 32'h0);
		// Short frame, underrun then clear
		add_step(WR_REG, vtb_pkg::ADR_CTL, 32'h0000_0017, 32'h0);
		add_step(STRM_FRAME, 4'h0, V_ACT - 2, 32'h0);
		add_step(RD_REG, vtb_pkg::ADR_STA, 32'h0000_0002, 32'h0000_0003);	// Underrun, unlocked
		add_step(WR_REG, vtb_pkg::ADR_STA, 32'h0000_0000, 32'h0);
		add_step(RD_REG, vtb_pkg::ADR_STA, 32'h0000_0000, 32'h0000_0002);
		add_step(WR_REG, vtb_pkg::ADR_CTL, 32'h0000_0000, 32'h0);
	endtask

	// Hard limit on run length
	initial
	begin
		repeat (WDOG_CYC) @(posedge vid_clk);
		abort_run("Simulation ran past its cycle limit");
	end

	initial
	begin
		step_t s;
		vtb_pkg::lb_dat_t got;
		lb_req = '0;
		lb_vld = 1'b0;
		axis = '0;
		axis_vld = 1'b0;
		build_table();
		wait_reset();
		check_vid("vid", vid, '0);
		check_bit("axis_rdy", axis_rdy, 1'b0);
		check_bit("lb_rd_vld", lb_rd_vld, 1'b0);
		check_bit("lb_rdy", lb_rdy, 1'b1);
		foreach (steps[i])
		begin
			s = steps[i];
			case (s.kind)
				WR_REG:
					bus_write(s.adr, s.dat);
				RD_REG:
				begin
					bus_read(s.adr, got);
					check_dat($sformatf("lb_rdata adr %h", s.adr), got & s.msk, s.dat);
				end
				TPG_FRAME:
					check_frame(1'b1, H_TOTAL * V_TOTAL);
				STRM_FRAME:
				begin
					exp_q.delete();
					fork
						send_frame(int'(s.dat));
						check_frame(1'b0, (V_ACT + 1) * H_TOTAL);	// Ends before frame 2
					join
					if (exp_q.size() != 0)
						abort_run("Stream words were missing from the video output");
				end
				FIFO_FILL:
					fill_fifo();
				default:
					abort_run("Unknown step in the stimulus table");
			endcase
		end
		@(posedge vid_clk);
		$display("Finished with no errors");
		$finish;
	end

endmodule

// File: test/vtb_tb_clk.sv
// ########################################
// Testbench clock and reset
// 100 ns clock, rst_n low for 4 rising edges
// ########################################

`timescale 1ns/1ns

module vtb_tb_clk
(
	output logic	vid_clk,
	output logic	rst_n
);

	initial
	begin
		vid_clk = 1'b0;
		forever #50 vid_clk = ~vid_clk;		// 100 ns period
	end

	initial
	begin
		rst_n = 1'b0;
		repeat (4) @(posedge vid_clk);
		rst_n <= 1'b1;		// Released on the 4th edge
	end

endmodule
